// File: filelist.f
rtl/ex_pkg.sv
rtl/operand_latch.sv
rtl/alu.sv
rtl/muldiv_unit.sv
rtl/result_merge.sv
rtl/ex_unit_top.sv
sim/tb_ex_unit.sv

// File: rtl/alu.sv
`default_nettype none

module alu (
    input  ex_pkg::ex_req_t op,
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    output logic [31:0]     alu_result,
    output logic            br_taken
);
    import ex_pkg::*;

    logic [4:0]      shamt;
    logic [xlen-1:0] arith;
    logic            lt;
    logic            eq;
    logic            gt;
    logic            cmp_bit;

    assign shamt = b[4:0];

    always_comb begin
        case (op.alu_op)
            alu_add:  arith = a + b;
            alu_sub:  arith = a - b;
            alu_and:  arith = a & b;
            alu_or:   arith = a | b;
            alu_xor:  arith = a ^ b;
            alu_nor:  arith = ~(a | b);
            alu_sll:  arith = a << shamt;
            alu_srl:  arith = a >> shamt;
            alu_sra:  arith = $signed(a) >>> shamt;
            alu_slt:  arith = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: arith = {31'b0, a < b};
            default:  arith = '0;
        endcase
    end

    // ------------------------------
    // Three-way compare on rj, rk
    // ------------------------------
    always_comb begin
        eq = (op.rj == op.rk);
        if (op.cmp_cond.is_signed) begin
            lt = $signed(op.rj) < $signed(op.rk);
        end else begin
            lt = op.rj < op.rk;
        end
        gt = !lt && !eq;
    end

    assign cmp_bit = (lt && op.cmp_cond.lt) ||
                     (eq && op.cmp_cond.eq) ||
                     (gt && op.cmp_cond.gt);

    assign alu_result = (op.op_class == class_cmp) ? {31'b0, cmp_bit} : arith;
    assign br_taken   = (op.op_class == class_cmp) && op.branch && cmp_bit;

endmodule

`default_nettype wire

// File: rtl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int xlen          = 32;
    localparam int reg_idx_w     = 5;
    localparam int muldiv_cycles = 32;
    localparam int md_cnt_w      = $clog2(muldiv_cycles);

    // ------------------------------
    // Decode encodings
    // ------------------------------
    typedef enum logic [1:0] {
        class_alu = 2'd0,
        class_cmp = 2'd1,
        class_mul = 2'd2,
        class_div = 2'd3
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_nor  = 4'd5,
        alu_sll  = 4'd6,
        alu_srl  = 4'd7,
        alu_sra  = 4'd8,
        alu_slt  = 4'd9,
        alu_sltu = 4'd10
    } alu_op_t;

    typedef enum logic [2:0] {
        mul_lo  = 3'b000,
        mul_hi  = 3'b001,
        mul_hiu = 3'b010,
        div_q   = 3'b100,
        div_r   = 3'b101,
        div_qu  = 3'b110,
        div_ru  = 3'b111
    } muldiv_op_t;

    typedef enum logic [1:0] {
        src1_rj   = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_t;

    typedef enum logic {
        src2_rk  = 1'b0,
        src2_imm = 1'b1
    } src2_sel_t;

    // Bit 3 signed, then lt, eq, gt enables.
    typedef struct packed {
        logic is_signed;
        logic lt;
        logic eq;
        logic gt;
    } cmp_cond_t;

    // ------------------------------
    // Stage payloads
    // ------------------------------
    typedef struct packed {
        op_class_t            op_class;
        alu_op_t              alu_op;
        muldiv_op_t           muldiv_op;
        src1_sel_t            src1_sel;
        src2_sel_t            src2_sel;
        cmp_cond_t            cmp_cond;
        logic                 branch;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      imm;
        logic [xlen-1:0]      rj;
        logic [xlen-1:0]      rk;
        logic [reg_idx_w-1:0] rd;
    } ex_req_t;

    typedef struct packed {
        logic [xlen-1:0]      result;
        logic                 br_taken;
        logic [reg_idx_w-1:0] rd;
    } ex_resp_t;

endpackage

`default_nettype wire

// File: rtl/ex_unit_top.sv
`default_nettype none

module ex_unit_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             in_valid,
    output logic             in_ready,
    input  ex_pkg::ex_req_t  in_req,
    output logic             out_valid,
    input  logic             out_ready,
    output ex_pkg::ex_resp_t out_resp
);
    import ex_pkg::*;

    logic            op_valid;
    ex_req_t         op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic            md_start;
    logic [xlen-1:0] md_result;
    logic            md_done;
    logic [xlen-1:0] alu_result;
    logic            br_taken;
    logic            pop;

    operand_latch u_latch (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_req   (in_req),
        .pop      (pop),
        .op_valid (op_valid),
        .op       (op),
        .a        (a),
        .b        (b),
        .md_start (md_start)
    );

    alu u_alu (
        .op         (op),
        .a          (a),
        .b          (b),
        .alu_result (alu_result),
        .br_taken   (br_taken)
    );

    // Multiply and divide take the raw register operands.
    muldiv_unit u_muldiv (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .md_start  (md_start),
        .md_op     (op.muldiv_op),
        .rj        (op.rj),
        .rk        (op.rk),
        .md_result (md_result),
        .md_done   (md_done)
    );

    result_merge u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .op         (op),
        .alu_result (alu_result),
        .br_taken   (br_taken),
        .md_result  (md_result),
        .md_done    (md_done),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_resp   (out_resp),
        .pop        (pop)
    );

endmodule

`default_nettype wire

// File: rtl/muldiv_unit.sv
`default_nettype none

module muldiv_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               md_start,
    input  ex_pkg::muldiv_op_t md_op,
    input  logic [31:0]        rj,
    input  logic [31:0]        rk,
    output logic [31:0]        md_result,
    output logic               md_done
);
    import ex_pkg::*;

    logic                busy;
    logic                done_q;
    logic [md_cnt_w-1:0] cnt;
    muldiv_op_t          sel;
    logic                is_div;
    logic                start_signed;
    logic                neg_a;
    logic                neg_b;
    logic                neg_res;  // Product or quotient sign.
    logic                neg_rem;
    logic [xlen-1:0]     dvs;      // Multiplicand or divisor magnitude.
    logic [2*xlen-1:0]   acc;
    logic [2*xlen-1:0]   acc_next;
    logic [2*xlen-1:0]   prod;
    logic [xlen:0]       add_sum;
    logic [xlen+1:0]     sub_diff;

    assign start_signed = md_op inside {mul_hi, div_q, div_r};
    assign neg_a        = start_signed && rj[xlen-1];
    assign neg_b        = start_signed && rk[xlen-1];
    assign is_div       = sel inside {div_q, div_r, div_qu, div_ru};

    // Done of the last operation is hidden while a new one starts.
    assign md_done = done_q && !md_start;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            cnt    <= '0;
        end else if (md_start) begin
            busy   <= 1'b1;
            done_q <= 1'b0;
            cnt    <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == md_cnt_w'(muldiv_cycles - 1)) begin
                busy   <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md_start) begin
            sel     <= md_op;
            dvs     <= neg_b ? -rk : rk;
            acc     <= {{xlen{1'b0}}, (neg_a ? -rj : rj)};
            neg_res <= (neg_a ^ neg_b) && (rk != '0); // Divide by zero stays all ones.
            neg_rem <= neg_a;
        end else if (busy) begin
            acc <= acc_next;
        end
    end

    // ------------------------------
    // One iteration
    // ------------------------------
    always_comb begin
        add_sum  = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, dvs} : '0);
        sub_diff = {1'b0, acc[2*xlen-1:xlen-1]} - {2'b00, dvs};
        if (!is_div) begin
            acc_next = {add_sum, acc[xlen-1:1]};
        end else if (!sub_diff[xlen+1]) begin
            acc_next = {sub_diff[xlen-1:0], acc[xlen-2:0], 1'b1};
        end else begin
            acc_next = {acc[2*xlen-2:0], 1'b0}; // Restore.
        end
    end

    // Sign fix and word select.
    always_comb begin
        prod = neg_res ? -acc : acc;
        case (sel)
            mul_lo:          md_result = prod[xlen-1:0];
            mul_hi, mul_hiu: md_result = prod[2*xlen-1:xlen];
            div_q, div_qu:   md_result = neg_res ? -acc[xlen-1:0] : acc[xlen-1:0];
            default:         md_result = neg_rem ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n) md_start |-> !busy)
        else $error("md_start during iteration");

endmodule

`default_nettype wire

// File: rtl/operand_latch.sv
`default_nettype none

module operand_latch (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            in_valid,
    output logic            in_ready,
    input  ex_pkg::ex_req_t in_req,
    input  logic            pop,
    output logic            op_valid,
    output ex_pkg::ex_req_t op,
    output logic [31:0]     a,
    output logic [31:0]     b,
    output logic            md_start
);
    import ex_pkg::*;

    logic load;
    logic load_md;

    // One slot. Refill while the current result leaves.
    assign in_ready = (!op_valid || pop) && !flush;
    assign load     = in_valid && in_ready;
    assign load_md  = load && (in_req.op_class inside {class_mul, class_div});

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            op_valid <= 1'b0;
            md_start <= 1'b0;
        end else begin
            md_start <= load_md; // High for one cycle after load.
            if (load) begin
                op_valid <= 1'b1;
            end else if (pop) begin
                op_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op <= in_req;
        end
    end

    // ------------------------------
    // Operand sources
    // ------------------------------
    always_comb begin
        case (op.src1_sel)
            src1_rj:  a = op.rj;
            src1_pc:  a = op.pc;
            default:  a = '0;
        endcase
    end

    always_comb begin
        case (op.src2_sel)
            src2_imm: b = op.imm;
            default:  b = op.rk;
        endcase
    end

    // A held request stays in place until its result leaves.
    assert property (@(posedge clk) disable iff (!rst_n)
        (op_valid && !pop && !flush) |=> (op_valid && $stable(op)))
        else $error("held request changed before its result left");

endmodule

`default_nettype wire

// File: rtl/result_merge.sv
`default_nettype none

module result_merge (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             op_valid,
    input  ex_pkg::ex_req_t  op,
    input  logic [31:0]      alu_result,
    input  logic             br_taken,
    input  logic [31:0]      md_result,
    input  logic             md_done,
    output logic             out_valid,
    input  logic             out_ready,
    output ex_pkg::ex_resp_t out_resp,
    output logic             pop
);
    import ex_pkg::*;

    logic     is_md;
    logic     stall_q;
    ex_resp_t resp_q;

    assign is_md     = op.op_class inside {class_mul, class_div};
    assign out_valid = op_valid && (!is_md || md_done);
    assign pop       = out_valid && out_ready;

    always_comb begin
        out_resp.rd = op.rd;
        if (is_md) begin
            out_resp.result   = md_result;
            out_resp.br_taken = 1'b0;
        end else begin
            out_resp.result   = alu_result;
            out_resp.br_taken = br_taken;
        end
    end

    // ------------------------------
    // Output hold check
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= out_valid && !out_ready;
        end
    end

    always_ff @(posedge clk) begin
        resp_q <= out_resp;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (stall_q && out_valid) |-> (out_resp == resp_q))
        else $error("out_resp changed under back-pressure");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_ex_unit -o tb_ex_unit

output=$(./obj_dir/tb_ex_unit)
echo "$output"

if echo "$output" | grep -qxF "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: sim/tb_ex_unit.sv
`default_nettype none

module tb_ex_unit;
    import ex_pkg::*;

    localparam int n_alu_reqs  = 43;
    localparam int n_cmp_reqs  = 96;
    localparam int n_mul_reqs  = 21;
    localparam int n_div_reqs  = 24;
    localparam int n_misc_reqs = 5;
    localparam int cycle_limit =
        40 * (n_alu_reqs + n_cmp_reqs + n_mul_reqs + n_div_reqs + n_misc_reqs) + 200;

    logic     clk;
    logic     rst_n;
    logic     flush;
    logic     in_valid;
    logic     in_ready;
    ex_req_t  in_req;
    logic     out_valid;
    logic     out_ready;
    ex_resp_t out_resp;

    logic [31:0] lfsr = 32'h3786;
    int          cycles;
    int          n_checks;
    int          n_errors;

    ex_unit_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_resp  (out_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // Stimulus and reference model
    // ------------------------------
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic ex_req_t base_req(op_class_t cls, logic [31:0] rj, logic [31:0] rk);
        ex_req_t r;
        r          = '0;
        r.op_class = cls;
        r.rj       = rj;
        r.rk       = rk;
        return r;
    endfunction

    function automatic ex_resp_t expected(ex_req_t r);
        ex_resp_t        e;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [4:0]      sh;
        logic            lt;
        logic            eq;
        logic            hit;
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     p;
        e    = '0;
        e.rd = r.rd;
        case (r.src1_sel)
            src1_rj: a = r.rj;
            src1_pc: a = r.pc;
            default: a = '0;
        endcase
        b  = (r.src2_sel == src2_imm) ? r.imm : r.rk;
        sh = b[4:0];
        sa = {{32{r.rj[31]}}, r.rj};
        sb = {{32{r.rk[31]}}, r.rk};
        ua = {32'b0, r.rj};
        ub = {32'b0, r.rk};
        case (r.op_class)
            class_alu: begin
                case (r.alu_op)
                    alu_add: e.result = a + b;
                    alu_sub: e.result = a - b;
                    alu_and: e.result = a & b;
                    alu_or:  e.result = a | b;
                    alu_xor: e.result = a ^ b;
                    alu_nor: e.result = ~(a | b);
                    alu_sll: e.result = a << sh;
                    alu_srl: e.result = a >> sh;
                    alu_sra: e.result = $signed(a) >>> sh;
                    alu_slt: e.result = {31'b0, $signed(a) < $signed(b)};
                    default: e.result = {31'b0, a < b};
                endcase
            end
            class_cmp: begin
                eq  = (r.rj == r.rk);
                lt  = r.cmp_cond.is_signed ? (sa < sb) : (ua < ub);
                hit = (lt && r.cmp_cond.lt) || (eq && r.cmp_cond.eq) ||
                      (!lt && !eq && r.cmp_cond.gt);
                e.result   = {31'b0, hit};
                e.br_taken = r.branch && hit;
            end
            class_mul: begin
                if (r.muldiv_op == mul_hi) begin
                    p = sa * sb;
                end else begin
                    p = ua * ub;
                end
                e.result = (r.muldiv_op == mul_lo) ? p[31:0] : p[63:32];
            end
            default: begin
                if (r.rk == '0) begin
                    e.result = (r.muldiv_op inside {div_q, div_qu}) ? '1 : r.rj;
                end else begin
                    case (r.muldiv_op)
                        div_q:   e.result = 32'(sa / sb);
                        div_r:   e.result = 32'(sa % sb);
                        div_qu:  e.result = r.rj / r.rk;
                        default: e.result = r.rj % r.rk;
                    endcase
                end
            end
        endcase
        return e;
    endfunction

    // ------------------------------
    // Handshake helpers
    // ------------------------------
    task automatic issue(input ex_req_t req);
        in_req   = req;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        in_valid = 1'b0;
    endtask

    task automatic wait_result(output ex_resp_t got);
        @(negedge clk);
        while (!out_valid) begin
            @(negedge clk);
        end
        got = out_resp;
        @(posedge clk); // Result leaves here.
        #10;
    endtask

    task automatic compare_resp(input ex_resp_t got, input ex_resp_t exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("FAIL t=%0t out_resp: got %h/%b/%0d, expected %h/%b/%0d",
                     $time, got.result, got.br_taken, got.rd,
                     exp.result, exp.br_taken, exp.rd);
        end
    endtask

    task automatic check_req(input ex_req_t req);
        ex_resp_t got;
        ex_resp_t exp;
        req.rd = 5'(rand_bits(5));
        exp    = expected(req);
        issue(req);
        wait_result(got);
        compare_resp(got, exp);
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("test %-12s %0d checks, %0d errors", name, n_checks - c0, n_errors - e0);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic alu_ops_test();
        ex_req_t     r;
        logic [31:0] x;
        logic [31:0] y;
        int          c0;
        int          e0;
        c0 = n_checks;
        e0 = n_errors;
        for (int i = 0; i <= 10; i++) begin
            r        = base_req(class_alu, rand_bits(32), rand_bits(32));
            r.alu_op = alu_op_t'(4'(i));
            check_req(r);
            r.src1_sel = src1_pc;
            r.pc       = rand_bits(32);
            r.src2_sel = src2_imm;
            r.imm      = rand_bits(32);
            check_req(r);
            r.src1_sel = src1_zero;
            check_req(r);
        end
        for (int i = 0; i < 6; i++) begin
            x        = rand_bits(32);
            y        = rand_bits(32);
            r        = base_req(class_alu, {1'b1, x[30:0]}, {y[31:5], i[0] ? 5'd31 : 5'd0});
            r.alu_op = (i < 2) ? alu_sll : ((i < 4) ? alu_srl : alu_sra);
            check_req(r);
        end
        for (int i = 0; i < 4; i++) begin
            x        = {1'b1, rand_bits(31)};  // Negative.
            y        = {1'b0, rand_bits(31)};
            r        = i[0] ? base_req(class_alu, x, y) : base_req(class_alu, y, x);
            r.alu_op = i[1] ? alu_sltu : alu_slt;
            check_req(r);
        end
        report_test("alu_ops", c0, e0);
    endtask

    task automatic compare_test();
        ex_req_t     r;
        logic [31:0] x;
        logic [31:0] y;
        int          c0;
        int          e0;
        c0 = n_checks;
        e0 = n_errors;
        for (int c = 0; c < 16; c++) begin
            for (int p = 0; p < 3; p++) begin
                for (int br = 0; br < 2; br++) begin
                    x = rand_bits(32);
                    y = rand_bits(32);
                    case (p)
                        0:       r = base_req(class_cmp, x, x);
                        1:       r = base_req(class_cmp, {1'b1, x[30:0]}, {1'b0, y[30:0]});
                        default: r = base_req(class_cmp, {1'b0, x[30:0]}, {1'b1, y[30:0]});
                    endcase
                    r.cmp_cond = 4'(c);
                    r.branch   = br[0];
                    check_req(r);
                end
            end
        end
        report_test("compare", c0, e0);
    endtask

    task automatic multiply_test();
        ex_req_t     r;
        logic [31:0] xs [0:6];
        logic [31:0] ys [0:6];
        muldiv_op_t  ops [0:2];
        int          c0;
        int          e0;
        c0  = n_checks;
        e0  = n_errors;
        ops = '{mul_lo, mul_hi, mul_hiu};
        xs  = '{32'h0, '1, '1, 32'h8000_0000, 32'h8000_0000, rand_bits(32), rand_bits(32)};
        ys  = '{rand_bits(32), '1, rand_bits(32), 32'h8000_0000, '1, rand_bits(32), 32'd7};
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 7; i++) begin
                r           = base_req(class_mul, xs[i], ys[i]);
                r.muldiv_op = ops[k];
                check_req(r);
            end
        end
        report_test("multiply", c0, e0);
    endtask

    task automatic divide_test();
        ex_req_t     r;
        logic [31:0] xs [0:5];
        logic [31:0] ys [0:5];
        muldiv_op_t  ops [0:3];
        int          c0;
        int          e0;
        c0  = n_checks;
        e0  = n_errors;
        ops = '{div_q, div_r, div_qu, div_ru};
        // Random, small divisor, negative dividend, zero, overflow, min by zero.
        xs  = '{rand_bits(32), rand_bits(32), 32'h8000_0000 | rand_bits(32),
                rand_bits(32), 32'h8000_0000, 32'h8000_0000};
        ys  = '{rand_bits(32), rand_bits(8), rand_bits(16), 32'h0, '1, 32'h0};
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 6; i++) begin
                r           = base_req(class_div, xs[i], ys[i]);
                r.muldiv_op = ops[k];
                check_req(r);
            end
        end
        report_test("divide", c0, e0);
    endtask

    task automatic backpressure_test();
        ex_req_t  r;
        ex_req_t  nxt;
        ex_resp_t got;
        ex_resp_t exp;
        int       c0;
        int       e0;
        c0          = n_checks;
        e0          = n_errors;
        r           = base_req(class_mul, rand_bits(32), rand_bits(32));
        r.muldiv_op = mul_hi;
        r.rd        = 5'd9;
        nxt         = base_req(class_alu, rand_bits(32), rand_bits(32));
        nxt.alu_op  = alu_sub;
        nxt.rd      = 5'd17;
        out_ready = 1'b0;
        issue(r);
        @(negedge clk);
        while (!out_valid) begin
            @(negedge clk);
        end
        got = out_resp;
        compare_resp(got, expected(r));
        @(posedge clk);
        #10;
        in_req   = nxt;   // Offered while the stage is full.
        in_valid = 1'b1;
        repeat (6) begin
            @(negedge clk);
            n_checks++;
            assert (out_valid && !in_ready) else begin
                n_errors++;
                $display("Handshake not held under back-pressure at t=%0t", $time);
            end
            compare_resp(out_resp, got);
        end
        @(posedge clk);
        #10;
        out_ready = 1'b1;
        issue(nxt);
        wait_result(got);
        exp = expected(nxt);
        compare_resp(got, exp);
        report_test("backpressure", c0, e0);
    endtask

    task automatic flush_test();
        ex_req_t r;
        ex_req_t drop;
        int      seen;
        int      c0;
        int      e0;
        c0          = n_checks;
        e0          = n_errors;
        seen        = 0;
        r           = base_req(class_div, rand_bits(32), rand_bits(32) | 32'd1);
        r.muldiv_op = div_q;
        drop        = base_req(class_alu, rand_bits(32), rand_bits(32));
        issue(r);
        repeat (10) @(posedge clk);
        #10;
        flush    = 1'b1;
        in_req   = drop;  // Must not be taken during flush.
        in_valid = 1'b1;
        @(negedge clk);
        n_checks++;
        assert (!in_ready) else begin
            n_errors++;
            $display("in_ready high during flush at t=%0t", $time);
        end
        @(posedge clk);
        #10;
        flush    = 1'b0;
        in_valid = 1'b0;
        repeat (muldiv_cycles + 8) begin
            @(negedge clk);
            if (out_valid) begin
                seen++;
            end
        end
        n_checks++;
        assert (seen == 0) else begin
            n_errors++;
            $display("A result appeared after the flush, in %0d cycles", seen);
        end
        @(posedge clk);
        #10;
        r        = base_req(class_alu, rand_bits(32), rand_bits(32));
        r.alu_op = alu_xor;
        check_req(r);
        report_test("flush", c0, e0);
    endtask

    initial begin
        n_checks  = 0;
        n_errors  = 0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        n_checks++;
        assert (in_ready && !out_valid) else begin
            n_errors++;
            $display("Wrong handshake state after reset at t=%0t", $time);
        end
        @(posedge clk);
        #10;
        alu_ops_test();
        compare_test();
        multiply_test();
        divide_test();
        backpressure_test();
        flush_test();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
